// File: hdl/mem_pkg.sv
package mem_pkg;

   // Data path and address width
   localparam int XLEN   = 32;
   localparam int STRB_W = XLEN / 8;

   // Lane sizes inside one word
   localparam int BYTE_W = 8;
   localparam int HALF_W = 16;

   // Byte offset within a word
   localparam int OFFS_W = $clog2(STRB_W);

   // RISC-V funct3 load/store size codes
   typedef enum logic [2:0] {
      MEM_B  = 3'b000,
      MEM_H  = 3'b001,
      MEM_W  = 3'b010,
      MEM_BU = 3'b100,
      MEM_HU = 3'b101
   } mem_size_e;

   // One data word, seen whole, as bytes or as halves
   typedef union packed {
      logic [XLEN-1:0]                    word;
      logic [STRB_W-1:0][BYTE_W-1:0]      bytes;
      logic [XLEN/HALF_W-1:0][HALF_W-1:0] halves;
   } mem_word_u;

endpackage

// File: hdl/store_aligner.sv
`timescale 1ns/1ns

module store_aligner
   import mem_pkg::*;
(
   input  mem_size_e         size_i,
   input  logic [OFFS_W-1:0] offset_i,
   input  logic [XLEN-1:0]   wdata_i,
   output logic [STRB_W-1:0] mask_o,
   output logic [XLEN-1:0]   wdata_o
);

   mem_word_u src_u;
   mem_word_u dst_u;

   assign src_u.word = wdata_i;

   always_comb begin
      dst_u.word = '0;
      mask_o     = '0;
      case (size_i)
         MEM_B, MEM_BU: begin
            // Low byte goes to the addressed lane
            dst_u.bytes[offset_i] = src_u.bytes[0];
            mask_o[offset_i]      = 1'b1;
         end
         MEM_H, MEM_HU: begin
            dst_u.halves[offset_i[1]] = src_u.halves[0];
            if (offset_i[1]) begin
               mask_o = 4'b1100;
            end else begin
               mask_o = 4'b0011;
            end
         end
         default: begin
            // Full word with all lanes written
            dst_u.word = src_u.word;
            mask_o     = '1;
         end
      endcase
   end

   assign wdata_o = dst_u.word;

endmodule

// File: hdl/load_aligner.sv
`timescale 1ns/1ns

module load_aligner
   import mem_pkg::*;
(
   input  logic              clk_i,
   input  logic              rstn_i,
   input  logic              accept_i,
   input  mem_size_e         size_i,
   input  logic [OFFS_W-1:0] offset_i,
   input  logic              word_done_i,
   input  logic [XLEN-1:0]   word_i,
   output logic              done_o,
   output logic [XLEN-1:0]   rdata_o
);

   mem_size_e         size_r;
   logic [OFFS_W-1:0] offset_r;

   mem_word_u         word_u;
   logic [BYTE_W-1:0] sel_byte;
   logic [HALF_W-1:0] sel_half;

   // Requester may move on once the access is taken
   always_ff @(posedge clk_i) begin
      if (accept_i) begin
         size_r   <= size_i;
         offset_r <= offset_i;
      end
   end

   assign word_u.word = word_i;
   assign sel_byte    = word_u.bytes[offset_r];
   assign sel_half    = word_u.halves[offset_r[1]];

   always_comb begin
      case (size_r)
         MEM_B:   rdata_o = {{(XLEN-BYTE_W){sel_byte[BYTE_W-1]}}, sel_byte};
         MEM_H:   rdata_o = {{(XLEN-HALF_W){sel_half[HALF_W-1]}}, sel_half};
         MEM_BU:  rdata_o = {{(XLEN-BYTE_W){1'b0}}, sel_byte};
         MEM_HU:  rdata_o = {{(XLEN-HALF_W){1'b0}}, sel_half};
         default: rdata_o = word_u.word;
      endcase
   end

   // Completion only valid outside reset
   assign done_o = word_done_i & rstn_i;

endmodule

// File: hdl/bus_unit.sv
`timescale 1ns/1ns

module bus_unit
   import mem_pkg::*;
#(
   parameter logic [XLEN-1:0] RAM_BASE = 32'h8000_0000,
   parameter logic [XLEN-1:0] RAM_MASK = 32'h0FFF_FFFF
) (
   input  logic              clk_i,
   input  logic              rstn_i,

   // Requester side
   input  logic              req_valid_i,
   input  logic              req_write_i,
   input  logic [XLEN-1:0]   req_addr_i,
   input  logic [STRB_W-1:0] st_mask_i,
   input  logic [XLEN-1:0]   st_data_i,
   output logic              ready_o,
   output logic              accept_o,
   output logic              done_o,
   output logic [XLEN-1:0]   word_o,

   // L1 request channel
   output logic [XLEN-1:0]   port_req_addr_o,
   output logic              port_req_valid_o,
   output logic              port_req_cacheable_o,
   output logic              port_req_write_o,
   output logic [XLEN-1:0]   port_req_wdata_o,
   output logic [STRB_W-1:0] port_req_mask_o,
   input  logic              port_req_ready_i,

   // L1 read data channel
   input  logic [XLEN-1:0]   port_rdata_i,
   input  logic              port_rvalid_i,
   output logic              port_rready_o
);

   localparam logic [1:0] S_IDLE = 2'd0;
   localparam logic [1:0] S_REQ  = 2'd1;
   localparam logic [1:0] S_WAIT = 2'd2;

   logic [1:0]        state_r;
   logic [1:0]        state_ns;

   logic [XLEN-1:0]   addr_r;
   logic [XLEN-1:0]   addr_ns;
   logic [STRB_W-1:0] mask_r;
   logic [STRB_W-1:0] mask_ns;
   logic [XLEN-1:0]   wdata_r;
   logic [XLEN-1:0]   wdata_ns;

   logic              read_r;
   logic              read_ns;
   logic              write_r;
   logic              write_ns;
   logic              cacheable_r;
   logic              cacheable_ns;

   logic              valid_ns;
   logic              in_window;
   logic              done_c;
   logic [XLEN-1:0]   word_c;

   assign ready_o   = (state_r == S_IDLE);
   assign accept_o  = ready_o && req_valid_i;
   assign in_window = (req_addr_i & ~RAM_MASK) == RAM_BASE;

   always_comb begin
      state_ns     = state_r;
      addr_ns      = addr_r;
      mask_ns      = mask_r;
      wdata_ns     = wdata_r;
      read_ns      = read_r;
      write_ns     = write_r;
      cacheable_ns = cacheable_r;
      valid_ns     = 1'b0;
      done_c       = 1'b0;
      word_c       = '0;

      case (state_r)
         S_IDLE: begin
            write_ns     = 1'b0;
            cacheable_ns = 1'b0;
            if (req_valid_i) begin
               valid_ns     = 1'b1;
               addr_ns      = req_addr_i;
               mask_ns      = st_mask_i;
               wdata_ns     = st_data_i;
               read_ns      = !req_write_i;
               write_ns     = req_write_i;
               cacheable_ns = in_window;
               if (port_req_ready_i) begin
                  // Request goes out in the acceptance cycle
                  state_ns = req_write_i ? S_IDLE : S_WAIT;
                  done_c   = req_write_i;
               end else begin
                  state_ns = S_REQ;
               end
            end
         end
         S_REQ: begin
            valid_ns = 1'b1;
            if (port_req_ready_i) begin
               state_ns = read_r ? S_WAIT : S_IDLE;
               done_c   = !read_r;
            end
         end
         S_WAIT: begin
            write_ns     = 1'b0;
            cacheable_ns = 1'b0;
            if (port_rvalid_i && port_rready_o) begin
               done_c   = 1'b1;
               word_c   = port_rdata_i;
               state_ns = S_IDLE;
            end
         end
         default: begin
            state_ns = S_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         state_r     <= S_IDLE;
         read_r      <= 1'b0;
         write_r     <= 1'b0;
         cacheable_r <= 1'b0;
      end else begin
         state_r     <= state_ns;
         read_r      <= read_ns;
         write_r     <= write_ns;
         cacheable_r <= cacheable_ns;
      end
   end

   always_ff @(posedge clk_i) begin
      addr_r  <= addr_ns;
      mask_r  <= mask_ns;
      wdata_r <= wdata_ns;
   end

   // Port sees next-state values so a request can leave on acceptance
   assign port_req_addr_o      = {addr_ns[XLEN-1:OFFS_W], {OFFS_W{1'b0}}};
   assign port_req_valid_o     = valid_ns;
   assign port_req_cacheable_o = cacheable_ns;
   assign port_req_write_o     = write_ns;
   assign port_req_wdata_o     = wdata_ns;
   assign port_req_mask_o      = mask_ns;
   assign port_rready_o        = (state_r == S_WAIT);

   assign done_o = done_c;
   assign word_o = word_c;

endmodule

// File: hdl/mem_stage.sv
`timescale 1ns/1ns

module mem_stage
   import mem_pkg::*;
#(
   parameter logic [XLEN-1:0] RAM_BASE = 32'h8000_0000,
   parameter logic [XLEN-1:0] RAM_MASK = 32'h0FFF_FFFF
) (
   input  logic              clk_i,
   input  logic              rstn_i,

   // Execute stage side
   input  logic              req_valid_i,
   input  logic              req_write_i,
   input  mem_size_e         req_size_i,
   input  logic [XLEN-1:0]   req_addr_i,
   input  logic [XLEN-1:0]   req_wdata_i,
   output logic              ready_o,
   output logic              done_o,
   output logic [XLEN-1:0]   rdata_o,

   // L1 data cache port
   output logic [XLEN-1:0]   port_req_addr_o,
   output logic              port_req_valid_o,
   output logic              port_req_cacheable_o,
   output logic              port_req_write_o,
   output logic [XLEN-1:0]   port_req_wdata_o,
   output logic [STRB_W-1:0] port_req_mask_o,
   input  logic              port_req_ready_i,
   input  logic [XLEN-1:0]   port_rdata_i,
   input  logic              port_rvalid_i,
   output logic              port_rready_o
);

   logic [OFFS_W-1:0] offset;
   logic [STRB_W-1:0] st_mask;
   logic [XLEN-1:0]   st_data;
   logic              accept;
   logic              word_done;
   logic [XLEN-1:0]   word;

   assign offset = req_addr_i[OFFS_W-1:0];

   store_aligner u_store_aligner (
      .size_i   (req_size_i),
      .offset_i (offset),
      .wdata_i  (req_wdata_i),
      .mask_o   (st_mask),
      .wdata_o  (st_data)
   );

   bus_unit #(
      .RAM_BASE (RAM_BASE),
      .RAM_MASK (RAM_MASK)
   ) u_bus_unit (
      .clk_i                (clk_i),
      .rstn_i               (rstn_i),
      .req_valid_i          (req_valid_i),
      .req_write_i          (req_write_i),
      .req_addr_i           (req_addr_i),
      .st_mask_i            (st_mask),
      .st_data_i            (st_data),
      .ready_o              (ready_o),
      .accept_o             (accept),
      .done_o               (word_done),
      .word_o               (word),
      .port_req_addr_o      (port_req_addr_o),
      .port_req_valid_o     (port_req_valid_o),
      .port_req_cacheable_o (port_req_cacheable_o),
      .port_req_write_o     (port_req_write_o),
      .port_req_wdata_o     (port_req_wdata_o),
      .port_req_mask_o      (port_req_mask_o),
      .port_req_ready_i     (port_req_ready_i),
      .port_rdata_i         (port_rdata_i),
      .port_rvalid_i        (port_rvalid_i),
      .port_rready_o        (port_rready_o)
   );

   load_aligner u_load_aligner (
      .clk_i       (clk_i),
      .rstn_i      (rstn_i),
      .accept_i    (accept),
      .size_i      (req_size_i),
      .offset_i    (offset),
      .word_done_i (word_done),
      .word_i      (word),
      .done_o      (done_o),
      .rdata_o     (rdata_o)
   );

endmodule

// File: tb/l1_port_model.sv
`timescale 1ns/1ns

module l1_port_model
   import mem_pkg::*;
#(
   parameter logic [31:0] SEED = 32'd5346
) (
   input  logic              clk_i,
   input  logic              rstn_i,
   input  logic [XLEN-1:0]   req_addr_i,
   input  logic              req_valid_i,
   input  logic              req_write_i,
   input  logic [XLEN-1:0]   req_wdata_i,
   input  logic [STRB_W-1:0] req_mask_i,
   output logic              req_ready_o,
   output logic [XLEN-1:0]   rdata_o,
   output logic              rvalid_o,
   input  logic              rready_i
);

   logic [XLEN-1:0] mem [256];
   logic [31:0]     lfsr_q = SEED;
   logic [1:0]      delay_q;
   logic            pend_q;

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v      = {v[30:0], lfsr_q[0]};
         lfsr_q = (lfsr_q >> 1) ^ (lfsr_q[0] ? 32'h8020_0003 : 32'h0);
      end
      return v;
   endfunction

   initial begin
      req_ready_o <= 1'b0;
      rvalid_o    <= 1'b0;
      rdata_o     <= '0;
   end

   always @(posedge clk_i) begin : respond
      logic [31:0] r;
      if (!rstn_i) begin
         for (int i = 0; i < 256; i++) begin
            mem[i] <= 32'h9E37_79B9 * (i + 1);
         end
         req_ready_o <= 1'b0;
         rvalid_o    <= 1'b0;
         rdata_o     <= '0;
         delay_q     <= '0;
         pend_q      <= 1'b0;
      end else begin
         r = rand_bits(1);
         req_ready_o <= r[0];
         if (req_valid_i && req_ready_o) begin
            if (req_write_i) begin
               for (int b = 0; b < STRB_W; b++) begin
                  if (req_mask_i[b]) begin
                     mem[req_addr_i[9:2]][8*b +: 8] <= req_wdata_i[8*b +: 8];
                  end
               end
            end else begin
               // Extra read latency of 0 to 3 cycles
               r       = rand_bits(2);
               delay_q <= r[1:0];
               rdata_o <= mem[req_addr_i[9:2]];
               pend_q  <= 1'b1;
            end
         end
         if (rvalid_o && rready_i) begin
            rvalid_o <= 1'b0;
         end
         if (pend_q) begin
            if (delay_q == 2'd0) begin
               rvalid_o <= 1'b1;
               pend_q   <= 1'b0;
            end else begin
               delay_q <= delay_q - 2'd1;
            end
         end
      end
   end

endmodule

// File: tb/tb_mem_stage.sv
`timescale 1ns/1ns

module tb_mem_stage
   import mem_pkg::*;
();

   localparam logic [XLEN-1:0] RAM_BASE   = 32'h8000_0000;
   localparam logic [XLEN-1:0] RAM_MASK   = 32'h0FFF_FFFF;
   localparam int              N_ACCESS   = 32 + 12 + 26 + 16 + 40;
   localparam int              MAX_CYCLES = 40 * N_ACCESS;

   logic              clk_i;
   logic              rstn_i;
   logic              req_valid;
   logic              req_write;
   mem_size_e         req_size;
   logic [XLEN-1:0]   req_addr;
   logic [XLEN-1:0]   req_wdata;
   logic              ready;
   logic              done;
   logic [XLEN-1:0]   rdata;
   logic [XLEN-1:0]   port_addr;
   logic              port_valid;
   logic              port_cacheable;
   logic              port_write;
   logic [XLEN-1:0]   port_wdata;
   logic [STRB_W-1:0] port_mask;
   logic              port_ready;
   logic [XLEN-1:0]   port_rdata;
   logic              port_rvalid;
   logic              port_rready;

   logic [31:0]       lfsr_q = 32'd5346;
   logic [XLEN-1:0]   shadow [256];
   logic [XLEN-1:0]   exp_q [$];
   logic [69:0]       held_q;
   logic              stall_q;
   logic              in_flight_q;
   logic [XLEN+1:0]   cur_req;
   logic [STRB_W-1:0] cur_mask;
   int                cycle_cnt = 0;
   int                acc_cnt = 0;
   int                done_cnt = 0;
   int                chk_cnt = 0;
   int                err_cnt = 0;

   mem_stage #(
      .RAM_BASE (RAM_BASE),
      .RAM_MASK (RAM_MASK)
   ) dut (
      .clk_i (clk_i), .rstn_i (rstn_i),
      .req_valid_i (req_valid), .req_write_i (req_write), .req_size_i (req_size),
      .req_addr_i (req_addr), .req_wdata_i (req_wdata),
      .ready_o (ready), .done_o (done), .rdata_o (rdata),
      .port_req_addr_o (port_addr), .port_req_valid_o (port_valid),
      .port_req_cacheable_o (port_cacheable), .port_req_write_o (port_write),
      .port_req_wdata_o (port_wdata), .port_req_mask_o (port_mask),
      .port_req_ready_i (port_ready), .port_rdata_i (port_rdata),
      .port_rvalid_i (port_rvalid), .port_rready_o (port_rready)
   );

   l1_port_model #(.SEED(32'd5346)) l1 (
      .clk_i (clk_i), .rstn_i (rstn_i),
      .req_addr_i (port_addr), .req_valid_i (port_valid), .req_write_i (port_write),
      .req_wdata_i (port_wdata), .req_mask_i (port_mask), .req_ready_o (port_ready),
      .rdata_o (port_rdata), .rvalid_o (port_rvalid), .rready_i (port_rready)
   );

   initial begin
      clk_i = 1'b0;
      forever #10 clk_i = ~clk_i;
   end

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v      = {v[30:0], lfsr_q[0]};
         lfsr_q = (lfsr_q >> 1) ^ (lfsr_q[0] ? 32'h8020_0003 : 32'h0);
      end
      return v;
   endfunction

   function automatic logic [XLEN-1:0] window_addr();
      logic [XLEN-1:0] a;
      a = rand_bits(32);
      return (RAM_BASE | (a & RAM_MASK)) & ~32'h3;
   endfunction

   function automatic mem_size_e pick_size();
      logic [31:0] r;
      r = rand_bits(3) % 5;
      case (r)
         0: return MEM_B;
         1: return MEM_H;
         2: return MEM_W;
         3: return MEM_BU;
         default: return MEM_HU;
      endcase
   endfunction

   function automatic logic [STRB_W-1:0] lane_mask(input mem_size_e sz, input logic [1:0] off);
      case (sz)
         MEM_B, MEM_BU: return 4'b0001 << off;
         MEM_H, MEM_HU: return 4'b0011 << off;
         default: return 4'b1111;
      endcase
   endfunction

   // Only the masked lanes take the shifted store data
   function automatic logic [XLEN-1:0] ref_store(input logic [XLEN-1:0] old, input mem_size_e sz,
                                                 input logic [1:0] off, input logic [XLEN-1:0] d);
      logic [STRB_W-1:0] m;
      logic [XLEN-1:0]   lanes;
      m = lane_mask(sz, off);
      for (int b = 0; b < STRB_W; b++) begin
         lanes[8*b +: 8] = {8{m[b]}};
      end
      return (old & ~lanes) | ((d << (8 * off)) & lanes);
   endfunction

   function automatic logic [XLEN-1:0] ref_load(input logic [XLEN-1:0] word, input mem_size_e sz,
                                                input logic [1:0] off);
      logic [XLEN-1:0] sh;
      sh = word >> (8 * off);
      case (sz)
         MEM_B:   return {{24{sh[7]}}, sh[7:0]};
         MEM_H:   return {{16{sh[15]}}, sh[15:0]};
         MEM_BU:  return {24'h0, sh[7:0]};
         MEM_HU:  return {16'h0, sh[15:0]};
         default: return word;
      endcase
   endfunction

   task automatic check_value(input string name, input logic [69:0] want,
                              input logic [69:0] got);
      chk_cnt++;
      if (want !== got) begin
         err_cnt++;
         $display("** Error at %0t ns: %s expected %0h, got %0h", $time, name, want, got);
      end
   endtask

   task automatic report_test(input string name, input int errs_before);
      if (err_cnt == errs_before) begin
         $display("%s: ok", name);
      end else begin
         $display("%s: %0d errors", name, err_cnt - errs_before);
      end
   endtask

   task automatic access(input logic wr, input mem_size_e sz, input logic [XLEN-1:0] a,
                         input logic [XLEN-1:0] d);
      int          target;
      logic [31:0] r;
      target = done_cnt + 1;
      @(posedge clk_i);
      req_valid <= 1'b1;
      req_write <= wr;
      req_size  <= sz;
      req_addr  <= a;
      req_wdata <= d;
      @(negedge clk_i);
      while (!ready) begin
         @(negedge clk_i);
      end
      @(posedge clk_i);
      // Inputs may change once the access is taken
      r = rand_bits(32);
      req_valid <= 1'b0;
      req_size  <= MEM_W;
      req_addr  <= r;
      req_wdata <= ~r;
      while (done_cnt < target) begin
         @(posedge clk_i);
      end
   endtask

   task automatic random_accesses(input int n, input logic window_only);
      logic [XLEN-1:0] a;
      logic [XLEN-1:0] d;
      logic [31:0]     w;
      mem_size_e       sz;
      for (int i = 0; i < n; i++) begin
         a = rand_bits(32);
         if (window_only || i % 2 == 1) begin
            a = RAM_BASE | (a & RAM_MASK);
         end
         if (window_only) begin
            // Few words so that loads hit earlier stores
            a[9:5] = 5'd0;
         end
         sz = pick_size();
         if (sz == MEM_W) begin
            a[1:0] = 2'b00;
         end else if (sz == MEM_H || sz == MEM_HU) begin
            a[0] = 1'b0;
         end
         w = rand_bits(1);
         d = rand_bits(32);
         access(w[0], sz, a, d);
      end
   endtask

   always @(negedge clk_i) begin : monitor
      logic            accept_now;
      logic [7:0]      idx;
      logic [XLEN-1:0] want;
      if (!rstn_i) begin
         for (int i = 0; i < 256; i++) begin
            shadow[i] = 32'h9E37_79B9 * (i + 1);
         end
         stall_q     = 1'b0;
         in_flight_q = 1'b0;
      end else begin
         accept_now = req_valid && ready;
         if (in_flight_q) begin
            check_value("ready_o", 0, ready);
         end
         if (accept_now) begin
            acc_cnt++;
            idx      = req_addr[9:2];
            cur_req  = {req_addr[XLEN-1:2], 2'b00, req_write,
                        ((req_addr >= RAM_BASE) && (req_addr <= RAM_BASE + RAM_MASK))};
            cur_mask = lane_mask(req_size, req_addr[1:0]);
            if (req_write) begin
               shadow[idx] = ref_store(shadow[idx], req_size, req_addr[1:0], req_wdata);
               exp_q.push_back('0);
            end else begin
               exp_q.push_back(ref_load(shadow[idx], req_size, req_addr[1:0]));
            end
         end
         if (stall_q) begin
            check_value("port_req_valid_o", 1, port_valid);
            check_value("port_req fields", held_q,
                        {port_addr, port_write, port_wdata, port_mask, port_cacheable});
         end
         if (port_valid && port_ready) begin
            check_value("port_req addr/write/cacheable", cur_req,
                        {port_addr, port_write, port_cacheable});
            if (cur_req[1]) begin
               check_value("port_req_mask_o", cur_mask, port_mask);
            end
         end
         stall_q = port_valid && !port_ready;
         held_q  = {port_addr, port_write, port_wdata, port_mask, port_cacheable};
         if (done) begin
            done_cnt++;
            if (exp_q.size() == 0) begin
               err_cnt++;
               $display("done_o pulsed at %0t ns with no access in flight", $time);
            end else begin
               want = exp_q.pop_front();
               check_value("rdata_o", want, rdata);
            end
         end
         in_flight_q = accept_now ? !done : (in_flight_q && !done);
      end
   end

   always @(posedge clk_i) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("Timeout after %0d cycles, the run did not complete", cycle_cnt);
         $display("TEST FAILED");
         $finish;
      end
   end

   initial begin
      int              errs;
      logic [XLEN-1:0] a;
      logic [XLEN-1:0] d;
      rstn_i    = 1'b0;
      req_valid = 1'b0;
      req_write = 1'b0;
      req_size  = MEM_W;
      req_addr  = '0;
      req_wdata = '0;
      repeat (8) @(posedge clk_i);
      rstn_i <= 1'b1;

      errs = err_cnt;
      @(negedge clk_i);
      check_value("ready_o", 1, ready);
      check_value("port_req_valid_o", 0, port_valid);
      check_value("port_rready_o", 0, port_rready);
      check_value("done_o", 0, done);
      report_test("after reset", errs);

      errs = err_cnt;
      for (int i = 0; i < 16; i++) begin
         a = window_addr();
         d = rand_bits(32);
         access(1'b1, MEM_W, a, d);
         access(1'b0, MEM_W, a, '0);
      end
      report_test("word store and load", errs);

      errs = err_cnt;
      for (int off = 0; off < 4; off++) begin
         a = window_addr();
         d = rand_bits(32);
         access(1'b1, MEM_B, a + off, d);
         access(1'b0, MEM_W, a, '0);
         if (off % 2 == 0) begin
            d = rand_bits(32);
            access(1'b1, MEM_H, a + off, d);
            access(1'b0, MEM_W, a, '0);
         end
      end
      report_test("byte and half stores", errs);

      errs = err_cnt;
      for (int r = 0; r < 2; r++) begin
         a = window_addr();
         d = rand_bits(32);
         // Sign bits set in every lane on the first round
         if (r == 0) begin
            d = d | 32'h8080_8080;
         end
         access(1'b1, MEM_W, a, d);
         for (int off = 0; off < 4; off++) begin
            access(1'b0, MEM_B, a + off, '0);
            access(1'b0, MEM_BU, a + off, '0);
            if (off % 2 == 0) begin
               access(1'b0, MEM_H, a + off, '0);
               access(1'b0, MEM_HU, a + off, '0);
            end
         end
      end
      report_test("sub-word loads", errs);

      errs = err_cnt;
      random_accesses(16, 1'b0);
      report_test("cacheability", errs);

      errs = err_cnt;
      random_accesses(40, 1'b1);
      report_test("back-pressure", errs);

      if (exp_q.size() != 0 || done_cnt != acc_cnt || acc_cnt != N_ACCESS) begin
         err_cnt++;
         $display("Access count mismatch: %0d accepted, %0d completed", acc_cnt, done_cnt);
      end
      $display("Accesses %0d, checks %0d, errors %0d", acc_cnt, chk_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// File: all.f
hdl/mem_pkg.sv
hdl/store_aligner.sv
hdl/load_aligner.sv
hdl/bus_unit.sv
hdl/mem_stage.sv
tb/l1_port_model.sv
tb/tb_mem_stage.sv

// File: Bender.yml
package:
  name: mem_stage

sources:
  - files:
      - hdl/mem_pkg.sv
      - hdl/store_aligner.sv
      - hdl/load_aligner.sv
      - hdl/bus_unit.sv
      - hdl/mem_stage.sv
  - target: test
    files:
      - tb/l1_port_model.sv
      - tb/tb_mem_stage.sv
